// ==== vlog.f ====
+incdir+verification
logic/rv32_isa_pkg.sv
logic/rv32_bus_pkg.sv
logic/rv32_decoder.sv
logic/rv32_alu.sv
logic/rv32_next_pc.sv
logic/rv32_lsu.sv
logic/rv32_retire.sv
logic/rv32_comb_core.sv
verification/rv32_comb_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module rv32_comb_core_tb \
	-Mdir obj_dir -o rv32_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/rv32_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

// ==== verification/rv32_tb_vectors.svh ====
/* Stimulus and expected-value table that the core testbench includes. Each row holds insn, pc,
   rs1, rs2, mem rdata, readies, random rs2 and CSR kind, then the expected rd_wdata, pc_next,
   pc_next_valid, ports used, mem addr, wdata, wstrb, rmask, trap and complete */
`ifndef RV32_TB_VECTORS_SVH
`define RV32_TB_VECTORS_SVH

task automatic load_vectors();
	add_row(32'hC00022F3, 32'h100, 32'h0, 32'h0, 32'h0, 4'hF, 1'b1, CSR_CYC, // rdcycle
		32'h0, 32'h104, 1'b1, 3'b001, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h002081B3, 32'h100, 32'h5, 32'h7, 32'h0, 4'hF, 1'b0, CSR_NONE, // add
		32'hC, 32'h104, 1'b1, 3'b111, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h402081B3, 32'h100, 32'h5, 32'h7, 32'h0, 4'hF, 1'b0, CSR_NONE, // sub
		32'hFFFFFFFE, 32'h104, 1'b1, 3'b111, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h0020A1B3, 32'h100, 32'hFFFFFFFF, 32'h1, 32'h0, 4'hF, 1'b0, CSR_NONE,
		32'h1, 32'h104, 1'b1, 3'b111, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h0020B1B3, 32'h100, 32'hFFFFFFFF, 32'h1, 32'h0, 4'hF, 1'b0, CSR_NONE,
		32'h0, 32'h104, 1'b1, 3'b111, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h4020D1B3, 32'h100, 32'h80000000, 32'h4, 32'h0, 4'hF, 1'b0, CSR_NONE,
		32'hF8000000, 32'h104, 1'b1, 3'b111, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h0020C1B3, 32'h102, 32'hF0F0, 32'h0FF0, 32'h0, 4'hF, 1'b0, CSR_NONE,
		32'hFF00, 32'h104, 1'b1, 3'b111, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'hFFF08193, 32'h100, 32'h10, 32'h0, 32'h0, 4'hF, 1'b1, CSR_NONE, // addi -1
		32'hF, 32'h104, 1'b1, 3'b101, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h4040D193, 32'h100, 32'h80000010, 32'h0, 32'h0, 4'hF, 1'b1, CSR_NONE,
		32'hF8000001, 32'h104, 1'b1, 3'b101, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h002001B3, 32'h100, 32'h55, 32'h9, 32'h0, 4'hF, 1'b0, CSR_NONE, // x0 source
		32'h9, 32'h104, 1'b1, 3'b111, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h123451B7, 32'h100, 32'h0, 32'h0, 32'h0, 4'hF, 1'b1, CSR_NONE, // lui
		32'h12345000, 32'h104, 1'b1, 3'b001, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h00001197, 32'h100, 32'h0, 32'h0, 32'h0, 4'hF, 1'b1, CSR_NONE, // auipc
		32'h1100, 32'h104, 1'b1, 3'b001, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h00208863, 32'h200, 32'h3, 32'h3, 32'h0, 4'hF, 1'b0, CSR_NONE, // beq taken
		32'h0, 32'h210, 1'b1, 3'b110, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h00208863, 32'h200, 32'h3, 32'h4, 32'h0, 4'hF, 1'b0, CSR_NONE,
		32'h0, 32'h204, 1'b1, 3'b110, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h0020C863, 32'h200, 32'hFFFFFFFF, 32'h1, 32'h0, 4'hF, 1'b0, CSR_NONE, // blt
		32'h0, 32'h210, 1'b1, 3'b110, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h0020F863, 32'h200, 32'h1, 32'hFFFFFFFF, 32'h0, 4'hF, 1'b0, CSR_NONE, // bgeu
		32'h0, 32'h204, 1'b1, 3'b110, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h008001EF, 32'h300, 32'h0, 32'h0, 32'h0, 4'hF, 1'b1, CSR_NONE, // jal +8
		32'h304, 32'h308, 1'b1, 3'b001, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h003081E7, 32'h400, 32'h1000, 32'h0, 32'h0, 4'hF, 1'b1, CSR_NONE, // jalr +3
		32'h404, 32'h1002, 1'b1, 3'b101, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h00408183, 32'h100, 32'h2000, 32'h0, 32'h12345680, 4'hF, 1'b1, CSR_NONE, // lb
		32'hFFFFFF80, 32'h104, 1'b1, 3'b101, 32'h2004, 32'h0, 4'h0, 4'h1, 1'b0, 1'b1);
	add_row(32'h0040C183, 32'h100, 32'h2000, 32'h0, 32'h12345680, 4'hF, 1'b1, CSR_NONE, // lbu
		32'h80, 32'h104, 1'b1, 3'b101, 32'h2004, 32'h0, 4'h0, 4'h1, 1'b0, 1'b1);
	add_row(32'h00409183, 32'h100, 32'h2000, 32'h0, 32'h8001, 4'hF, 1'b1, CSR_NONE, // lh
		32'hFFFF8001, 32'h104, 1'b1, 3'b101, 32'h2004, 32'h0, 4'h0, 4'h3, 1'b0, 1'b1);
	add_row(32'h0040D183, 32'h100, 32'h2000, 32'h0, 32'h8001, 4'hF, 1'b1, CSR_NONE, // lhu
		32'h8001, 32'h104, 1'b1, 3'b101, 32'h2004, 32'h0, 4'h0, 4'h3, 1'b0, 1'b1);
	add_row(32'h0040A183, 32'h100, 32'h2000, 32'h0, 32'hDEADBEEF, 4'hF, 1'b1, CSR_NONE, // lw
		32'hDEADBEEF, 32'h104, 1'b1, 3'b101, 32'h2004, 32'h0, 4'h0, 4'hF, 1'b0, 1'b1);
	add_row(32'h0020A423, 32'h100, 32'h3000, 32'hCAFEF00D, 32'h0, 4'hF, 1'b0, CSR_NONE, // sw
		32'h0, 32'h104, 1'b1, 3'b110, 32'h3008, 32'hCAFEF00D, 4'hF, 4'h0, 1'b0, 1'b1);
	add_row(32'h00208423, 32'h100, 32'h3000, 32'hCAFEF00D, 32'h0, 4'hF, 1'b0, CSR_NONE, // sb
		32'h0, 32'h104, 1'b1, 3'b110, 32'h3008, 32'hCAFEF00D, 4'h1, 4'h0, 1'b0, 1'b1);
	add_row(32'h00209423, 32'h100, 32'h3000, 32'hCAFEF00D, 32'h0, 4'hF, 1'b0, CSR_NONE, // sh
		32'h0, 32'h104, 1'b1, 3'b110, 32'h3008, 32'hCAFEF00D, 4'h3, 4'h0, 1'b0, 1'b1);
	add_row(32'hFFFFFFFF, 32'h500, 32'h1, 32'h2, 32'h0, 4'hF, 1'b0, CSR_NONE, // bad opcode
		32'h0, 32'h500, 1'b1, 3'b000, 32'h0, 32'h0, 4'h0, 4'h0, 1'b1, 1'b1);
	add_row(32'h022081B3, 32'h500, 32'h1, 32'h2, 32'h0, 4'hF, 1'b0, CSR_NONE, // mul encoding
		32'h0, 32'h500, 1'b1, 3'b000, 32'h0, 32'h0, 4'h0, 4'h0, 1'b1, 1'b1);
	add_row(32'h00208863, 32'h200, 32'h3, 32'h3, 32'h0, 4'b1011, 1'b0, CSR_NONE, // rs2 stall
		32'h0, 32'h210, 1'b0, 3'b110, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b0);
	add_row(32'h00208863, 32'h200, 32'h3, 32'h3, 32'h0, 4'hF, 1'b0, CSR_NONE,
		32'h0, 32'h210, 1'b1, 3'b110, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'h008001EF, 32'h300, 32'h0, 32'h0, 32'h0, 4'b1101, 1'b1, CSR_NONE, // rd stall
		32'h304, 32'h308, 1'b0, 3'b001, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b0);
	add_row(32'h0040A183, 32'h100, 32'h2000, 32'h0, 32'h1234, 4'b1110, 1'b1, CSR_NONE,
		32'h1234, 32'h104, 1'b1, 3'b101, 32'h2004, 32'h0, 4'h0, 4'hF, 1'b0, 1'b0);
	add_row(32'hFFF08193, 32'h100, 32'h10, 32'h0, 32'h0, 4'b0111, 1'b1, CSR_NONE, // rs1 stall
		32'hF, 32'h104, 1'b1, 3'b101, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b0);
	add_row(32'hFFF08193, 32'h100, 32'h10, 32'h0, 32'h0, 4'b1011, 1'b1, CSR_NONE, // unused rs2
		32'hF, 32'h104, 1'b1, 3'b101, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'hC00022F3, 32'h100, 32'h0, 32'h0, 32'h0, 4'hF, 1'b1, CSR_CYC,
		32'h0, 32'h104, 1'b1, 3'b001, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'hC02022F3, 32'h100, 32'h0, 32'h0, 32'h0, 4'hF, 1'b1, CSR_RET, // rdinstret
		32'h0, 32'h104, 1'b1, 3'b001, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'hC01022F3, 32'h100, 32'h0, 32'h0, 32'h0, 4'hF, 1'b1, CSR_TIM, // rdtime
		32'h0, 32'h104, 1'b1, 3'b001, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
	add_row(32'hC82022F3, 32'h100, 32'h0, 32'h0, 32'h0, 4'hF, 1'b1, CSR_NONE, // rdinstreth
		32'h0, 32'h104, 1'b1, 3'b001, 32'h0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b1);
endtask

`endif

// ==== verification/rv32_comb_core_tb.sv ====
/* Table-driven testbench for the single-cycle RV32I core.
   Applies one table row per clock and compares every core output with the row. */
`default_nettype none

module rv32_comb_core_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rv32_isa_pkg::*;
	import rv32_bus_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 10;

	typedef enum logic [1:0] {CSR_NONE, CSR_CYC, CSR_RET, CSR_TIM} csr_chk_e;

	typedef struct packed {
		xlen_t      insn;
		xlen_t      pc;
		xlen_t      rs1;
		xlen_t      rs2;
		xlen_t      mrd;
		logic [3:0] ready;     // rs1, rs2, rd, mem
		logic       rand_rs2;  // rs2 data unused, drive random
		csr_chk_e   csr;       // Counter read, expected value tracked here
		xlen_t      exp_wdata;
		xlen_t      exp_pc_next;
		logic       exp_pcv;
		logic [2:0] exp_used;  // rs1, rs2, rd port valid
		mem_req_t   exp_mem;
		logic       exp_trap;
		logic       exp_cpl;
	} row_t;

	logic             clk = 1'b0;
	logic             arst_n;
	xlen_t            pc;
	xlen_t            insn;
	logic             insn_valid;
	xlen_t            rs1_rdata;
	xlen_t            rs2_rdata;
	xlen_t            mem_rdata;
	logic             rs1_ready;
	logic             rs2_ready;
	logic             rd_ready;
	logic             mem_ready;
	logic [CNT_W-1:0] csr_time;
	xlen_t            insn_addr;
	reg_port_t        rs1_port;
	reg_port_t        rs2_port;
	reg_port_t        rd_port;
	mem_req_t         mem;
	xlen_t            rd_wdata;
	xlen_t            pc_next;
	logic             pc_next_valid;
	logic             insn_complete;
	logic             trap;

	row_t             rows[$];
	logic             rows_loaded = 1'b0;
	logic [CNT_W-1:0] cycles_seen = '0; // Clock edges since reset release
	int               retired = 0;
	int               checks = 0;
	int               errors = 0;
	int               cur_row = -1;

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		if (arst_n) begin
			cycles_seen <= cycles_seen + 64'd1;
		end
	end

	rv32_comb_core rv32_comb_core_i (
		.clk(clk), .arst_n(arst_n), .pc(pc), .insn(insn), .insn_valid(insn_valid),
		.rs1_rdata(rs1_rdata), .rs2_rdata(rs2_rdata), .mem_rdata(mem_rdata),
		.rs1_ready(rs1_ready), .rs2_ready(rs2_ready), .rd_ready(rd_ready),
		.mem_ready(mem_ready), .csr_time(csr_time), .insn_addr(insn_addr),
		.rs1_port(rs1_port), .rs2_port(rs2_port), .rd_port(rd_port), .mem(mem),
		.rd_wdata(rd_wdata), .pc_next(pc_next), .pc_next_valid(pc_next_valid),
		.insn_complete(insn_complete), .trap(trap)
	);

	task automatic add_row(input xlen_t i, input xlen_t p, input xlen_t r1, input xlen_t r2,
		input xlen_t md, input logic [3:0] rdy, input logic rnd, input csr_chk_e csr,
		input xlen_t wd, input xlen_t pcn, input logic pcv, input logic [2:0] used,
		input xlen_t ma, input xlen_t mw, input logic [3:0] strb, input logic [3:0] mask,
		input logic tr, input logic cpl);
		row_t r;
		r = '{insn: i, pc: p, rs1: r1, rs2: r2, mrd: md, ready: rdy, rand_rs2: rnd,
			csr: csr, exp_wdata: wd, exp_pc_next: pcn, exp_pcv: pcv, exp_used: used,
			exp_mem: '{valid: |(strb | mask), instr: 1'b0, addr: ma, wdata: mw,
				wstrb: strb, rmask: mask},
			exp_trap: tr, exp_cpl: cpl};
		rows.push_back(r);
	endtask

	`include "rv32_tb_vectors.svh"

	function automatic reg_port_t expect_port(input reg_addr_t idx, input logic used);
		reg_port_t p;
		p.addr    = used ? idx : 5'd0;
		p.valid   = used;
		p.request = used && (idx != 5'd0); // x0 is never requested
		return p;
	endfunction

	task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: row %0d %s got %h expected %h", $time, cur_row, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: row %0d %s got %b expected %b", $time, cur_row, what, got, exp);
		end
	endtask

	task automatic check_port(input string what, input reg_port_t got, input reg_port_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: row %0d %s got %h expected %h", $time, cur_row, what, got, exp);
		end
	endtask

	task automatic check_mem(input mem_req_t got, input mem_req_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: row %0d mem got %h expected %h", $time, cur_row, got, exp);
		end
	endtask

	task automatic drive_row(input row_t r);
		insn       <= r.insn;
		pc         <= r.pc;
		insn_valid <= 1'b1;
		rs1_rdata  <= r.rs1;
		rs2_rdata  <= r.rand_rs2 ? $urandom : r.rs2;
		mem_rdata  <= r.mrd;
		rs1_ready  <= r.ready[3];
		rs2_ready  <= r.ready[2];
		rd_ready   <= r.ready[1];
		mem_ready  <= r.ready[0];
	endtask

	task automatic check_row(input row_t r);
		xlen_t exp_wdata;
		exp_wdata = r.exp_wdata;
		case (r.csr)
			CSR_CYC: exp_wdata = cycles_seen[31:0];
			CSR_RET: exp_wdata = xlen_t'(retired); // Rows before this one
			CSR_TIM: exp_wdata = csr_time[31:0];
			default: ;
		endcase
		check_word("insn_addr", insn_addr, {r.pc[31:2], 2'b00});
		check_word("rd_wdata", rd_wdata, exp_wdata);
		check_word("pc_next", pc_next, r.exp_pc_next);
		check_flag("pc_next_valid", pc_next_valid, r.exp_pcv);
		check_flag("trap", trap, r.exp_trap);
		check_flag("insn_complete", insn_complete, r.exp_cpl);
		check_mem(mem, r.exp_mem);
		check_port("rs1_port", rs1_port, expect_port(r.insn[19:15], r.exp_used[2]));
		check_port("rs2_port", rs2_port, expect_port(r.insn[24:20], r.exp_used[1]));
		check_port("rd_port", rd_port, expect_port(r.insn[11:7], r.exp_used[0]));
	endtask

	initial begin
		int limit_ns;
		wait (rows_loaded);
		limit_ns = (rows.size() + RESET_CYCLES + 4) * CLK_PERIOD + 100;
		#(limit_ns);
		$display("Watchdog expired before all table rows were applied");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'hb03e_816c));
		arst_n     = 1'b0;
		pc         = '0;
		insn       = '0;
		insn_valid = 1'b0;
		rs1_rdata  = '0;
		rs2_rdata  = '0;
		mem_rdata  = '0;
		rs1_ready  = 1'b0;
		rs2_ready  = 1'b0;
		rd_ready   = 1'b0;
		mem_ready  = 1'b0;
		csr_time   = {$urandom, $urandom};
		load_vectors();
		rows_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_flag("idle trap", trap, 1'b0); // No instruction presented yet
		check_flag("idle insn_complete", insn_complete, 1'b0);
		check_flag("idle pc_next_valid", pc_next_valid, 1'b0);
		check_mem(mem, '0);
		check_port("idle rs1_port", rs1_port, '0);
		check_port("idle rs2_port", rs2_port, '0);
		check_port("idle rd_port", rd_port, '0);
		foreach (rows[i]) begin
			@(posedge clk);
			drive_row(rows[i]);
			@(negedge clk);
			cur_row = i;
			check_row(rows[i]);
			if (rows[i].exp_cpl && !rows[i].exp_trap) begin
				retired++;
			end
		end
		$display("Checks run %0d, errors found %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/rv32_comb_core.sv ====
/* Single-cycle RV32I core top. One instruction per clock with register,
   memory and completion results produced combinationally. */
`default_nettype none

module rv32_comb_core (
	input  wire logic                           clk,
	input  wire logic                           arst_n,
	input  wire rv32_isa_pkg::xlen_t            pc,
	input  wire rv32_isa_pkg::xlen_t            insn,
	input  wire logic                           insn_valid,
	input  wire rv32_isa_pkg::xlen_t            rs1_rdata,
	input  wire rv32_isa_pkg::xlen_t            rs2_rdata,
	input  wire rv32_isa_pkg::xlen_t            mem_rdata,
	input  wire logic                           rs1_ready,
	input  wire logic                           rs2_ready,
	input  wire logic                           rd_ready,
	input  wire logic                           mem_ready,
	input  wire logic [rv32_isa_pkg::CNT_W-1:0] csr_time,
	output rv32_isa_pkg::xlen_t                 insn_addr,
	output rv32_bus_pkg::reg_port_t             rs1_port,
	output rv32_bus_pkg::reg_port_t             rs2_port,
	output rv32_bus_pkg::reg_port_t             rd_port,
	output rv32_bus_pkg::mem_req_t              mem,
	output rv32_isa_pkg::xlen_t                 rd_wdata,
	output rv32_isa_pkg::xlen_t                 pc_next,
	output logic                                pc_next_valid,
	output logic                                insn_complete,
	output logic                                trap
);
	import rv32_isa_pkg::*;

	decoded_t dec;
	xlen_t    alu_result;
	xlen_t    load_data;
	xlen_t    link_addr;
	logic     branch_taken;

	assign insn_addr = {pc[31:2], 2'b00}; // Word aligned, no compressed instructions
	assign link_addr = insn_addr + 32'd4;

	rv32_decoder rv32_decoder_i (
		.clk(clk), .insn(insn), .insn_valid(insn_valid), .insn_addr(insn_addr),
		.rs1_rdata(rs1_rdata), .rs2_rdata(rs2_rdata), .dec(dec),
		.rs1_port(rs1_port), .rs2_port(rs2_port), .rd_port(rd_port)
	);

	rv32_alu rv32_alu_i (
		.dec(dec), .alu_result(alu_result), .branch_taken(branch_taken)
	);

	rv32_lsu rv32_lsu_i (
		.clk(clk), .dec(dec), .mem_rdata(mem_rdata), .mem(mem), .load_data(load_data)
	);

	rv32_next_pc rv32_next_pc_i (
		.dec(dec), .pc(pc), .insn_addr(insn_addr), .branch_taken(branch_taken),
		.insn_complete(insn_complete), .insn_valid(insn_valid), .trap(trap),
		.pc_next(pc_next), .pc_next_valid(pc_next_valid)
	);

	rv32_retire rv32_retire_i (
		.clk(clk), .arst_n(arst_n), .insn_valid(insn_valid), .dec(dec),
		.rs1_port(rs1_port), .rs2_port(rs2_port), .rd_port(rd_port), .mem(mem),
		.rs1_ready(rs1_ready), .rs2_ready(rs2_ready), .rd_ready(rd_ready),
		.mem_ready(mem_ready), .alu_result(alu_result), .load_data(load_data),
		.link_addr(link_addr), .csr_time(csr_time), .insn_complete(insn_complete),
		.trap(trap), .rd_wdata(rd_wdata)
	);

endmodule

`default_nettype wire

// ==== logic/rv32_retire.sv ====
/* Completion and trap rules, write-back mux and the cycle/instret counters.
   The counters are the only state of the core. */
`default_nettype none

module rv32_retire (
	input  wire logic                                 clk,
	input  wire logic                                 arst_n,
	input  wire logic                                 insn_valid,
	input  wire rv32_isa_pkg::decoded_t               dec,
	input  wire rv32_bus_pkg::reg_port_t              rs1_port,
	input  wire rv32_bus_pkg::reg_port_t              rs2_port,
	input  wire rv32_bus_pkg::reg_port_t              rd_port,
	input  wire rv32_bus_pkg::mem_req_t               mem,
	input  wire logic                                 rs1_ready,
	input  wire logic                                 rs2_ready,
	input  wire logic                                 rd_ready,
	input  wire logic                                 mem_ready,
	input  wire rv32_isa_pkg::xlen_t                  alu_result,
	input  wire rv32_isa_pkg::xlen_t                  load_data,
	input  wire rv32_isa_pkg::xlen_t                  link_addr,
	input  wire logic [rv32_isa_pkg::CNT_W-1:0]       csr_time,
	output logic                                      insn_complete,
	output logic                                      trap,
	output rv32_isa_pkg::xlen_t                       rd_wdata
);
	import rv32_isa_pkg::*;

	logic [CNT_W-1:0] cycle;
	logic [CNT_W-1:0] instret;
	xlen_t            csr_rdata;
	logic             rs1_ok;
	logic             rs2_ok;
	logic             rd_ok;
	logic             mem_ok;

	// An unused access is always satisfied
	assign rs1_ok = !rs1_port.valid || rs1_ready;
	assign rs2_ok = !rs2_port.valid || rs2_ready;
	assign rd_ok  = !rd_port.valid || rd_ready;
	assign mem_ok = !mem.valid || mem_ready;

	assign insn_complete = insn_valid && rs1_ok && rs2_ok && rd_ok && mem_ok;
	assign trap          = insn_valid && dec.illegal;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cycle   <= '0;
			instret <= '0;
		end else begin
			cycle <= cycle + 1'b1;
			if (insn_complete && !trap) begin
				instret <= instret + 1'b1;
			end
		end
	end

	always_comb begin
		case (dec.csr_addr)
			CSR_CYCLE:    csr_rdata = cycle[XLEN-1:0];
			CSR_TIME:     csr_rdata = csr_time[XLEN-1:0];
			CSR_INSTRET:  csr_rdata = instret[XLEN-1:0];
			CSR_CYCLEH:   csr_rdata = cycle[CNT_W-1:XLEN];
			CSR_TIMEH:    csr_rdata = csr_time[CNT_W-1:XLEN];
			CSR_INSTRETH: csr_rdata = instret[CNT_W-1:XLEN];
			default:      csr_rdata = '0;
		endcase
	end

	always_comb begin
		case (dec.wb_sel)
			WB_IMM:  rd_wdata = dec.imm;
			WB_ALU:  rd_wdata = alu_result;
			WB_LOAD: rd_wdata = load_data;
			WB_LINK: rd_wdata = link_addr;
			WB_CSR:  rd_wdata = csr_rdata;
			default: rd_wdata = '0;
		endcase
	end

	// Retirement can never outrun the clock
	a_instret_le_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		instret <= cycle);

endmodule

`default_nettype wire

// ==== logic/rv32_lsu.sv ====
/* Load/store unit: memory address, byte lanes and load data extension.
   Data is taken from and placed at the low lanes, no alignment shifting. */
`default_nettype none

module rv32_lsu (
	input  wire logic                   clk,
	input  wire rv32_isa_pkg::decoded_t dec,
	input  wire rv32_isa_pkg::xlen_t    mem_rdata,
	output rv32_bus_pkg::mem_req_t      mem,
	output rv32_isa_pkg::xlen_t         load_data
);
	import rv32_isa_pkg::*;

	logic [3:0] lanes;
	logic       is_load;
	logic       is_store;

	assign is_load  = !dec.illegal && dec.opcode == OPC_LOAD;
	assign is_store = !dec.illegal && dec.opcode == OPC_STORE;

	always_comb begin
		case (funct3_mem_e'(dec.funct3))
			F3_B, F3_BU: lanes = 4'b0001;
			F3_H, F3_HU: lanes = 4'b0011;
			default:     lanes = 4'b1111;
		endcase
	end

	always_comb begin
		mem       = '0; // Also keeps instr low
		mem.valid = is_load || is_store;
		if (mem.valid) begin
			mem.addr = dec.op_a + dec.imm;
		end
		if (is_store) begin
			mem.wdata = dec.op_b; // rs2 for stores
			mem.wstrb = lanes;
		end
		if (is_load) begin
			mem.rmask = lanes;
		end
	end

	always_comb begin
		case (funct3_mem_e'(dec.funct3))
			F3_B:    load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			F3_BU:   load_data = {24'b0, mem_rdata[7:0]};
			F3_H:    load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			F3_HU:   load_data = {16'b0, mem_rdata[15:0]};
			default: load_data = mem_rdata;
		endcase
	end

	// A request reads or writes, never both
	a_rw_excl: assert property (@(posedge clk) !((|mem.wstrb) && (|mem.rmask)));

endmodule

`default_nettype wire

// ==== logic/rv32_next_pc.sv ====
/* Next-pc selection for sequential flow, branches, JAL and JALR.
   Control transfers only report a valid target once the instruction completes. */
`default_nettype none

module rv32_next_pc (
	input  wire rv32_isa_pkg::decoded_t dec,
	input  wire rv32_isa_pkg::xlen_t    pc,
	input  wire rv32_isa_pkg::xlen_t    insn_addr,
	input  wire logic                   branch_taken,
	input  wire logic                   insn_complete,
	input  wire logic                   insn_valid,
	input  wire logic                   trap,
	output rv32_isa_pkg::xlen_t         pc_next,
	output logic                        pc_next_valid
);
	import rv32_isa_pkg::*;

	xlen_t seq_pc;
	xlen_t rel_target;
	xlen_t jalr_sum;

	assign seq_pc     = insn_addr + 32'd4;
	assign rel_target = insn_addr + dec.imm; // JAL and taken branches
	assign jalr_sum   = dec.op_a + dec.imm;

	always_comb begin
		pc_next       = seq_pc;
		pc_next_valid = insn_valid;
		case (dec.opcode)
			OPC_JAL: begin
				pc_next       = rel_target;
				pc_next_valid = insn_complete;
			end
			OPC_JALR: begin
				pc_next       = {jalr_sum[31:1], 1'b0};
				pc_next_valid = insn_complete;
			end
			OPC_BRANCH: begin
				if (branch_taken) begin
					pc_next = rel_target;
				end
				pc_next_valid = insn_complete;
			end
			default: ;
		endcase
		if (trap) begin
			pc_next = pc; // Park on the faulting instruction
		end
	end

endmodule

`default_nettype wire

// ==== logic/rv32_alu.sv ====
/* Integer ALU for OP and OP-IMM plus the branch condition check.
   Purely combinational, operands come from the decoder. */
`default_nettype none

module rv32_alu (
	input  wire rv32_isa_pkg::decoded_t dec,
	output rv32_isa_pkg::xlen_t         alu_result,
	output logic                        branch_taken
);
	import rv32_isa_pkg::*;

	logic [4:0] shamt;
	logic       eq;
	logic       lt;
	logic       ltu;
	logic       cond;

	assign shamt = dec.op_b[4:0];
	assign eq    = dec.op_a == dec.op_b;
	assign lt    = $signed(dec.op_a) < $signed(dec.op_b);
	assign ltu   = dec.op_a < dec.op_b;

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:  alu_result = dec.op_a + dec.op_b;
			ALU_SUB:  alu_result = dec.op_a - dec.op_b;
			ALU_SLL:  alu_result = dec.op_a << shamt;
			ALU_SLT:  alu_result = {31'b0, lt};
			ALU_SLTU: alu_result = {31'b0, ltu}; // Immediate already sign-extended
			ALU_XOR:  alu_result = dec.op_a ^ dec.op_b;
			ALU_SRL:  alu_result = dec.op_a >> shamt;
			ALU_SRA:  alu_result = $unsigned($signed(dec.op_a) >>> shamt);
			ALU_OR:   alu_result = dec.op_a | dec.op_b;
			ALU_AND:  alu_result = dec.op_a & dec.op_b;
			default:  alu_result = '0;
		endcase
	end

	always_comb begin
		case (funct3_branch_e'(dec.funct3))
			F3_BEQ:  cond = eq;
			F3_BNE:  cond = !eq;
			F3_BLT:  cond = lt;
			F3_BGE:  cond = !lt;
			F3_BLTU: cond = ltu;
			F3_BGEU: cond = !ltu;
			default: cond = 1'b0;
		endcase
	end

	assign branch_taken = (dec.opcode == OPC_BRANCH) && cond;

endmodule

`default_nettype wire

// ==== logic/rv32_decoder.sv ====
/* Decoder that splits instruction fields, builds immediates and operands and sets the register
   port requests. Any encoding outside the supported RV32I subset is flagged illegal. */
`default_nettype none

module rv32_decoder (
	input  wire logic                    clk,
	input  wire rv32_isa_pkg::xlen_t     insn,
	input  wire logic                    insn_valid,
	input  wire rv32_isa_pkg::xlen_t     insn_addr,
	input  wire rv32_isa_pkg::xlen_t     rs1_rdata,
	input  wire rv32_isa_pkg::xlen_t     rs2_rdata,
	output rv32_isa_pkg::decoded_t       dec,
	output rv32_bus_pkg::reg_port_t      rs1_port,
	output rv32_bus_pkg::reg_port_t      rs2_port,
	output rv32_bus_pkg::reg_port_t      rd_port
);
	import rv32_isa_pkg::*;

	logic [6:0] funct7;
	reg_addr_t  rs1_idx;
	reg_addr_t  rs2_idx;
	reg_addr_t  rd_idx;
	xlen_t      imm_i;
	xlen_t      imm_s;
	xlen_t      imm_b;
	xlen_t      imm_j;
	xlen_t      imm_u;
	xlen_t      rs1_val;
	xlen_t      rs2_val;
	logic       legal;
	logic       use_rs1;
	logic       use_rs2;
	logic       use_rd;

	function automatic rv32_bus_pkg::reg_port_t make_port(reg_addr_t idx, logic used);
		rv32_bus_pkg::reg_port_t p;
		p.addr    = used ? idx : '0;
		p.valid   = used;
		p.request = used && (idx != '0);
		return p;
	endfunction

	assign funct7  = insn[31:25];
	assign rs1_idx = insn[19:15];
	assign rs2_idx = insn[24:20];
	assign rd_idx  = insn[11:7];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};

	assign rs1_val = (rs1_idx == '0) ? '0 : rs1_rdata; // x0 reads as zero
	assign rs2_val = (rs2_idx == '0) ? '0 : rs2_rdata;

	always_comb begin
		dec          = '0;
		dec.opcode   = opcode_e'(insn[6:0]);
		dec.funct3   = insn[14:12];
		dec.alu_op   = ALU_ADD;
		dec.wb_sel   = WB_NONE;
		dec.imm      = imm_i;
		dec.csr_addr = insn[31:20];
		legal   = 1'b1;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_rd  = 1'b1;
		case (dec.opcode)
			OPC_LUI: begin
				dec.imm    = imm_u;
				dec.wb_sel = WB_IMM;
			end
			OPC_AUIPC: begin
				dec.imm    = imm_u;
				dec.wb_sel = WB_ALU;
			end
			OPC_JAL: begin
				dec.imm    = imm_j;
				dec.wb_sel = WB_LINK;
			end
			OPC_JALR: begin
				legal      = dec.funct3 == 3'b000;
				use_rs1    = 1'b1;
				dec.wb_sel = WB_LINK;
			end
			OPC_BRANCH: begin
				legal   = dec.funct3[2:1] != 2'b01; // 010 and 011 unused
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				use_rd  = 1'b0;
				dec.imm = imm_b;
			end
			OPC_LOAD: begin
				legal      = dec.funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU};
				use_rs1    = 1'b1;
				dec.wb_sel = WB_LOAD;
			end
			OPC_STORE: begin
				legal   = dec.funct3 inside {F3_B, F3_H, F3_W};
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				use_rd  = 1'b0;
				dec.imm = imm_s;
			end
			OPC_OP_IMM, OPC_OP: begin
				use_rs1    = 1'b1;
				use_rs2    = dec.opcode == OPC_OP;
				dec.wb_sel = WB_ALU;
				case (dec.funct3)
					3'd0: dec.alu_op = (use_rs2 && funct7[5]) ? ALU_SUB : ALU_ADD;
					3'd1: dec.alu_op = ALU_SLL;
					3'd2: dec.alu_op = ALU_SLT;
					3'd3: dec.alu_op = ALU_SLTU;
					3'd4: dec.alu_op = ALU_XOR;
					3'd5: dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
					3'd6: dec.alu_op = ALU_OR;
					default: dec.alu_op = ALU_AND;
				endcase
				if (use_rs2) begin
					legal = (funct7 == 7'h00) ||
						(funct7 == 7'h20 && (dec.funct3 == 3'd0 || dec.funct3 == 3'd5));
				end else if (dec.funct3 == 3'd1) begin
					legal = funct7 == 7'h00;
				end else if (dec.funct3 == 3'd5) begin
					legal = funct7 == 7'h00 || funct7 == 7'h20;
				end
			end
			OPC_SYSTEM: begin // CSRRS rd, counter, x0
				legal = dec.funct3 == 3'b010 && rs1_idx == '0 &&
					dec.csr_addr inside {CSR_CYCLE, CSR_TIME, CSR_INSTRET,
						CSR_CYCLEH, CSR_TIMEH, CSR_INSTRETH};
				dec.wb_sel = WB_CSR;
			end
			default: legal = 1'b0;
		endcase
		dec.illegal = !(insn_valid && legal);
		if (dec.illegal) begin // No accesses and no write-back
			use_rs1    = 1'b0;
			use_rs2    = 1'b0;
			use_rd     = 1'b0;
			dec.wb_sel = WB_NONE;
		end
		dec.op_a = (dec.opcode == OPC_AUIPC) ? insn_addr : rs1_val;
		dec.op_b = (dec.opcode inside {OPC_OP_IMM, OPC_LOAD, OPC_AUIPC, OPC_JALR}) ?
			dec.imm : rs2_val;
	end

	assign rs1_port = make_port(rs1_idx, use_rs1);
	assign rs2_port = make_port(rs2_idx, use_rs2);
	assign rd_port  = make_port(rd_idx, use_rd);

	// A request always comes with its valid
	a_port_req: assert property (@(posedge clk)
		(!rs1_port.request || rs1_port.valid) && (!rs2_port.request || rs2_port.valid) &&
		(!rd_port.request || rd_port.valid));

endmodule

`default_nettype wire

// ==== logic/rv32_bus_pkg.sv ====
/* Register-port and memory-request groups seen at the core boundary.
   Used by the core top, its units and the testbench. */
`default_nettype none

package rv32_bus_pkg;

	// One register file access per port
	typedef struct packed {
		rv32_isa_pkg::reg_addr_t addr;    // Zero when the port is unused
		logic                    valid;   // Instruction uses this port
		logic                    request; // Valid and index not x0
	} reg_port_t;

	// Data memory request, one per instruction at most
	typedef struct packed {
		logic                valid;
		logic                instr; // Always low, fetch is outside the core
		rv32_isa_pkg::xlen_t addr;
		rv32_isa_pkg::xlen_t wdata; // Unshifted, byte lanes from bit 0
		logic [3:0]          wstrb; // Stores only
		logic [3:0]          rmask; // Loads only
	} mem_req_t;

endpackage

`default_nettype wire

// ==== logic/rv32_isa_pkg.sv ====
/* RV32I encodings, CSR numbers and the decoded-instruction record.
   Imported by every unit of the single-cycle core. */
`default_nettype none

package rv32_isa_pkg;

	localparam int XLEN  = 32;
	localparam int CNT_W = 64; // Width of the cycle, time and instret counters

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [4:0]      reg_addr_t;

	// Major opcodes, insn[6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b01_101_11,
		OPC_AUIPC  = 7'b00_101_11,
		OPC_JAL    = 7'b11_011_11,
		OPC_JALR   = 7'b11_001_11,
		OPC_BRANCH = 7'b11_000_11,
		OPC_LOAD   = 7'b00_000_11,
		OPC_STORE  = 7'b01_000_11,
		OPC_OP_IMM = 7'b00_100_11,
		OPC_OP     = 7'b01_100_11,
		OPC_SYSTEM = 7'b11_100_11
	} opcode_e;

	typedef enum logic [2:0] {
		F3_BEQ  = 3'b000,
		F3_BNE  = 3'b001,
		F3_BLT  = 3'b100,
		F3_BGE  = 3'b101,
		F3_BLTU = 3'b110,
		F3_BGEU = 3'b111
	} funct3_branch_e;

	typedef enum logic [2:0] {
		F3_B  = 3'b000,
		F3_H  = 3'b001,
		F3_W  = 3'b010,
		F3_BU = 3'b100, // Loads only
		F3_HU = 3'b101  // Loads only
	} funct3_mem_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	// Read-only user counters
	localparam logic [11:0] CSR_CYCLE    = 12'hC00;
	localparam logic [11:0] CSR_TIME     = 12'hC01;
	localparam logic [11:0] CSR_INSTRET  = 12'hC02;
	localparam logic [11:0] CSR_CYCLEH   = 12'hC80;
	localparam logic [11:0] CSR_TIMEH    = 12'hC81;
	localparam logic [11:0] CSR_INSTRETH = 12'hC82;

	typedef enum logic [2:0] {WB_NONE, WB_IMM, WB_ALU, WB_LOAD, WB_LINK, WB_CSR} wb_sel_e;

	typedef struct packed {
		opcode_e     opcode;
		logic [2:0]  funct3;
		alu_op_e     alu_op;
		wb_sel_e     wb_sel;
		xlen_t       imm;      // Sign-extended, format picked by opcode
		xlen_t       op_a;     // rs1 or insn_addr
		xlen_t       op_b;     // rs2 or imm
		logic [11:0] csr_addr;
		logic        illegal;  // Also high when no instruction is presented
	} decoded_t;

endpackage

`default_nettype wire
